// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int xlen   = 64;
    localparam int addr_w = 12;  // csr address field of the instruction

    // ============================================================
    // machine csr addresses
    // ============================================================
    localparam logic [addr_w-1:0] addr_mstatus = 12'h300;
    localparam logic [addr_w-1:0] addr_mtvec   = 12'h305;
    localparam logic [addr_w-1:0] addr_mepc    = 12'h341;
    localparam logic [addr_w-1:0] addr_mcause  = 12'h342;

    // reset value with mpp = machine
    localparam logic [xlen-1:0] mstatus_reset = 64'h0000_0000_a000_1800;

    // mstatus bit positions
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mpp_lo       = 11;
    localparam int mpp_hi       = 12;

    // ============================================================
    // funct3 codes of the csr instructions
    // ============================================================
    localparam logic [2:0] f3_csrrw  = 3'd1;
    localparam logic [2:0] f3_csrrs  = 3'd2;
    localparam logic [2:0] f3_csrrc  = 3'd3;
    localparam logic [2:0] f3_csrrwi = 3'd5;
    localparam logic [2:0] f3_csrrsi = 3'd6;
    localparam logic [2:0] f3_csrrci = 3'd7;

    // encoding matches funct3[1:0] of the register forms
    typedef enum logic [1:0] {
        op_write = 2'd1,
        op_set   = 2'd2,
        op_clear = 2'd3
    } csr_op_e;

endpackage

`default_nettype wire

// ==== hdl/csr_access_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_access_if;

    logic [csr_pkg::addr_w-1:0] addr;     // target csr
    logic                       wen;      // write at the next rising clk
    logic [csr_pkg::xlen-1:0]   wdata;    // value after read-modify-write
    logic [csr_pkg::xlen-1:0]   rdata;    // current value at addr
    logic                       unknown;  // addr names none of the csrs

    // instruction side
    modport exec (
        output addr,
        output wen,
        output wdata,
        input  rdata,
        input  unknown
    );

    // register file side
    modport regs (
        input  addr,
        input  wen,
        input  wdata,
        output rdata,
        output unknown
    );

endinterface

`default_nettype wire

// ==== hdl/csr_op_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit (
    input  wire logic [csr_pkg::xlen-1:0] old_val,
    input  wire logic [csr_pkg::xlen-1:0] operand,
    input  wire csr_pkg::csr_op_e         op,
    output logic      [csr_pkg::xlen-1:0] new_val
);

    // ============================================================
    // read-modify-write
    // ============================================================
    always_comb begin
        case (op)
            csr_pkg::op_write: begin
                new_val = operand;  // csrrw and csrrwi
            end
            csr_pkg::op_set: begin
                new_val = old_val | operand;  // csrrs and csrrsi
            end
            csr_pkg::op_clear: begin
                new_val = old_val & ~operand;  // csrrc and csrrci
            end
            default: begin
                new_val = operand;  // the executor never writes with this code
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire logic                       clk,
    input  wire logic                       rst,
    csr_access_if.regs                      acc,
    input  wire logic                       raise_intr,
    input  wire logic [csr_pkg::xlen-1:0]   intr_cause,
    input  wire logic [csr_pkg::xlen-1:0]   pc,
    input  wire logic                       mret,
    output logic                            jmp,
    output logic      [csr_pkg::xlen-1:0]   next_pc
);

    logic [csr_pkg::xlen-1:0] mepc;
    logic [csr_pkg::xlen-1:0] mstatus;
    logic [csr_pkg::xlen-1:0] mcause;
    logic [csr_pkg::xlen-1:0] mtvec;

    logic trap_take;

    // ============================================================
    // read port
    // ============================================================
    always_comb begin
        acc.unknown = 1'b0;
        case (acc.addr)
            csr_pkg::addr_mstatus: begin
                acc.rdata = mstatus;
            end
            csr_pkg::addr_mtvec: begin
                acc.rdata = mtvec;
            end
            csr_pkg::addr_mepc: begin
                acc.rdata = mepc;
            end
            csr_pkg::addr_mcause: begin
                acc.rdata = mcause;
            end
            default: begin
                acc.rdata   = '0;
                acc.unknown = 1'b1;
            end
        endcase
    end

    // ============================================================
    // redirect
    // ============================================================
    // mret wins, then a csr write, and only then a pending trap
    assign trap_take = raise_intr & ~mret & ~acc.wen;

    assign jmp     = mret | trap_take;
    assign next_pc = mret ? mepc : mtvec;  // direct mode only

    // ============================================================
    // state update
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc    <= '0;
            mstatus <= csr_pkg::mstatus_reset;
            mcause  <= '0;
            mtvec   <= '0;
        end else if (mret) begin
            mstatus[csr_pkg::mpp_hi:csr_pkg::mpp_lo] <= 2'b00;
            mstatus[csr_pkg::mstatus_mie]  <= mstatus[csr_pkg::mstatus_mpie];
            mstatus[csr_pkg::mstatus_mpie] <= 1'b1;
        end else if (acc.wen) begin
            case (acc.addr)
                csr_pkg::addr_mstatus: begin
                    mstatus <= acc.wdata;
                end
                csr_pkg::addr_mtvec: begin
                    mtvec <= acc.wdata;
                end
                csr_pkg::addr_mepc: begin
                    mepc <= acc.wdata;
                end
                csr_pkg::addr_mcause: begin
                    mcause <= acc.wdata;
                end
                default: begin
                end
            endcase
        end else if (trap_take) begin
            mcause <= intr_cause;
            mepc   <= pc;
            mstatus[csr_pkg::mpp_hi:csr_pkg::mpp_lo] <= 2'b11;  // trap always lands in m-mode
            mstatus[csr_pkg::mstatus_mpie] <= mstatus[csr_pkg::mstatus_mie];
            mstatus[csr_pkg::mstatus_mie]  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csr_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_exec (
    input  wire logic [31:0]              instr,
    input  wire logic [csr_pkg::xlen-1:0] rs1_val,
    input  wire logic                     csr_valid,
    csr_access_if.exec                    acc,
    output logic      [csr_pkg::xlen-1:0] rd_data,
    output logic                          illegal
);

    logic [2:0]               funct3;
    logic [4:0]               src_field;  // rs1 index or zimm
    logic [csr_pkg::xlen-1:0] operand;
    csr_pkg::csr_op_e         op;
    logic                     use_imm;
    logic                     f3_legal;
    logic                     writes;

    assign funct3    = instr[14:12];
    assign src_field = instr[19:15];

    // ============================================================
    // funct3 decode
    // ============================================================
    always_comb begin
        use_imm  = 1'b0;
        f3_legal = 1'b1;
        case (funct3)
            csr_pkg::f3_csrrw: begin
                op = csr_pkg::op_write;
            end
            csr_pkg::f3_csrrs: begin
                op = csr_pkg::op_set;
            end
            csr_pkg::f3_csrrc: begin
                op = csr_pkg::op_clear;
            end
            csr_pkg::f3_csrrwi: begin
                op      = csr_pkg::op_write;
                use_imm = 1'b1;
            end
            csr_pkg::f3_csrrsi: begin
                op      = csr_pkg::op_set;
                use_imm = 1'b1;
            end
            csr_pkg::f3_csrrci: begin
                op      = csr_pkg::op_clear;
                use_imm = 1'b1;
            end
            default: begin
                op       = csr_pkg::op_write;  // funct3 0 and 4 are not csr ops
                f3_legal = 1'b0;
            end
        endcase
    end

    assign operand = use_imm ? {{(csr_pkg::xlen-5){1'b0}}, src_field} : rs1_val;

    // set and clear with x0 or zimm 0 are pure reads
    assign writes = f3_legal & ((op == csr_pkg::op_write) | (src_field != 5'd0));

    // ============================================================
    // access
    // ============================================================
    assign acc.addr = instr[31:20];
    assign acc.wen  = csr_valid & writes;

    csr_op_unit op_unit_i (
        .old_val (acc.rdata),
        .operand (operand),
        .op      (op),
        .new_val (acc.wdata)
    );

    // an unknown address only faults when it would be written
    assign illegal = csr_valid & (~f3_legal | (acc.unknown & writes));
    assign rd_data = csr_valid ? acc.rdata : '0;

endmodule

`default_nettype wire

// ==== hdl/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [31:0]              instr,
    input  wire logic [csr_pkg::xlen-1:0] rs1_val,
    input  wire logic                     csr_valid,
    input  wire logic                     raise_intr,
    input  wire logic [csr_pkg::xlen-1:0] intr_cause,
    input  wire logic [csr_pkg::xlen-1:0] pc,
    input  wire logic                     mret,
    output logic      [csr_pkg::xlen-1:0] rd_data,
    output logic                          illegal,
    output logic                          jmp,
    output logic      [csr_pkg::xlen-1:0] next_pc
);

    // ============================================================
    // executor to register file
    // ============================================================
    csr_access_if acc_if ();

    csr_exec exec_i (
        .instr     (instr),
        .rs1_val   (rs1_val),
        .csr_valid (csr_valid),
        .acc       (acc_if.exec),
        .rd_data   (rd_data),
        .illegal   (illegal)
    );

    // trap entry and mret live here with the registers they touch
    csr_regfile regfile_i (
        .clk        (clk),
        .rst        (rst),
        .acc        (acc_if.regs),
        .raise_intr (raise_intr),
        .intr_cause (intr_cause),
        .pc         (pc),
        .mret       (mret),
        .jmp        (jmp),
        .next_pc    (next_pc)
    );

endmodule

`default_nettype wire

// ==== test/csr_ref_model.svh ====
`ifndef csr_ref_model_svh
`define csr_ref_model_svh
`default_nettype none

// ============================================================
// model state with one field per machine csr
// ============================================================
typedef struct packed {
    logic [csr_pkg::xlen-1:0] mstatus;
    logic [csr_pkg::xlen-1:0] mtvec;
    logic [csr_pkg::xlen-1:0] mepc;
    logic [csr_pkg::xlen-1:0] mcause;
} csr_state_t;

function automatic csr_state_t reset_state();
    csr_state_t s;
    s         = '0;
    s.mstatus = 64'h0000_0000_a000_1800;  // only mstatus leaves reset nonzero
    return s;
endfunction

function automatic logic addr_known(input logic [11:0] addr);
    return (addr == csr_pkg::addr_mstatus) || (addr == csr_pkg::addr_mtvec) ||
           (addr == csr_pkg::addr_mepc) || (addr == csr_pkg::addr_mcause);
endfunction

function automatic logic [csr_pkg::xlen-1:0] read_reg(input csr_state_t s,
                                                     input logic [11:0] addr);
    case (addr)
        csr_pkg::addr_mstatus: return s.mstatus;
        csr_pkg::addr_mtvec:   return s.mtvec;
        csr_pkg::addr_mepc:    return s.mepc;
        csr_pkg::addr_mcause:  return s.mcause;
        default:               return '0;
    endcase
endfunction

// ============================================================
// expected outputs of one cycle and the state after its clock edge
// ============================================================
function automatic void predict_cycle(
    input  csr_state_t               cur,
    input  logic [31:0]              instr,
    input  logic [csr_pkg::xlen-1:0] rs1_val,
    input  logic                     valid,
    input  logic                     intr,
    input  logic [csr_pkg::xlen-1:0] cause,
    input  logic [csr_pkg::xlen-1:0] at_pc,
    input  logic                     ret,
    output csr_state_t               nxt,
    output logic [csr_pkg::xlen-1:0] exp_rd,
    output logic                     exp_illegal,
    output logic                     exp_jmp,
    output logic [csr_pkg::xlen-1:0] exp_next_pc
);
    logic [11:0]              addr;
    logic [2:0]               f3;
    logic [4:0]               fld;
    logic [csr_pkg::xlen-1:0] old;
    logic [csr_pkg::xlen-1:0] operand;
    logic [csr_pkg::xlen-1:0] new_val;
    logic                     legal;
    logic                     writes;
    logic                     trap;

    addr    = instr[31:20];
    f3      = instr[14:12];
    fld     = instr[19:15];
    old     = read_reg(cur, addr);
    legal   = (f3 != 3'd0) && (f3 != 3'd4);
    operand = f3[2] ? {{(csr_pkg::xlen-5){1'b0}}, fld} : rs1_val;
    case (f3[1:0])
        2'd1:    new_val = operand;
        2'd2:    new_val = old | operand;
        default: new_val = old & ~operand;
    endcase
    writes = valid && legal && ((f3[1:0] == 2'd1) || (fld != 5'd0));
    trap   = intr && !ret && !writes;  // an attempted write blocks the trap even if unknown

    exp_rd      = valid ? old : '0;
    exp_illegal = valid && (!legal || (writes && !addr_known(addr)));
    exp_jmp     = ret || trap;
    exp_next_pc = ret ? cur.mepc : cur.mtvec;

    nxt = cur;
    if (ret) begin
        nxt.mstatus[csr_pkg::mpp_hi:csr_pkg::mpp_lo] = 2'b00;
        nxt.mstatus[csr_pkg::mstatus_mie]  = cur.mstatus[csr_pkg::mstatus_mpie];
        nxt.mstatus[csr_pkg::mstatus_mpie] = 1'b1;
    end else if (writes) begin
        case (addr)
            csr_pkg::addr_mstatus: nxt.mstatus = new_val;
            csr_pkg::addr_mtvec:   nxt.mtvec   = new_val;
            csr_pkg::addr_mepc:    nxt.mepc    = new_val;
            csr_pkg::addr_mcause:  nxt.mcause  = new_val;
            default:               nxt         = cur;
        endcase
    end else if (trap) begin
        nxt.mcause = cause;
        nxt.mepc   = at_pc;
        nxt.mstatus[csr_pkg::mpp_hi:csr_pkg::mpp_lo] = 2'b11;
        nxt.mstatus[csr_pkg::mstatus_mpie] = cur.mstatus[csr_pkg::mstatus_mie];
        nxt.mstatus[csr_pkg::mstatus_mie]  = 1'b0;
    end
endfunction

`default_nettype wire
`endif

// ==== test/csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_ref_model.svh"
`default_nettype none

module csr_unit_tb;

    localparam int clk_period = 4;
    localparam int num_random = 3000;
    localparam int max_cycles = 4 + 200 + num_random;  // reset, directed part, random part

    logic                     clk;
    logic                     rst;
    logic [31:0]              instr;
    logic [csr_pkg::xlen-1:0] rs1_val;
    logic                     csr_valid;
    logic                     raise_intr;
    logic [csr_pkg::xlen-1:0] intr_cause;
    logic [csr_pkg::xlen-1:0] pc;
    logic                     mret;
    logic [csr_pkg::xlen-1:0] rd_data;
    logic                     illegal;
    logic                     jmp;
    logic [csr_pkg::xlen-1:0] next_pc;

    integer     seed = 32'he6b57072;
    int         errors = 0;
    int         checks = 0;
    csr_state_t model;

    csr_unit_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .rs1_val    (rs1_val),
        .csr_valid  (csr_valid),
        .raise_intr (raise_intr),
        .intr_cause (intr_cause),
        .pc         (pc),
        .mret       (mret),
        .rd_data    (rd_data),
        .illegal    (illegal),
        .jmp        (jmp),
        .next_pc    (next_pc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // ============================================================
    // helpers
    // ============================================================
    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [31:0] encode_instr(input logic [11:0] addr,
                                                 input logic [4:0] fld, input logic [2:0] f3);
        return {addr, fld, f3, 5'd10, 7'b1110011};  // rd = x10, SYSTEM opcode
    endfunction

    function automatic logic [11:0] known_addr(input logic [1:0] idx);
        case (idx)
            2'd0:    return csr_pkg::addr_mstatus;
            2'd1:    return csr_pkg::addr_mtvec;
            2'd2:    return csr_pkg::addr_mepc;
            default: return csr_pkg::addr_mcause;
        endcase
    endfunction

    // drives one cycle at the rising edge and compares the outputs at the falling edge
    task automatic drive_cycle(input logic [31:0] ins, input logic [63:0] rs1,
                               input logic valid, input logic intr, input logic [63:0] cause,
                               input logic [63:0] at_pc, input logic ret, input string name);
        csr_state_t  nxt;
        logic [63:0] exp_rd;
        logic        exp_illegal;
        logic        exp_jmp;
        logic [63:0] exp_next_pc;
        @(posedge clk);
        instr      <= ins;
        rs1_val    <= rs1;
        csr_valid  <= valid;
        raise_intr <= intr;
        intr_cause <= cause;
        pc         <= at_pc;
        mret       <= ret;
        @(negedge clk);
        predict_cycle(model, ins, rs1, valid, intr, cause, at_pc, ret,
                      nxt, exp_rd, exp_illegal, exp_jmp, exp_next_pc);
        check_val({name, " rd_data"}, exp_rd, rd_data);
        check_val({name, " illegal"}, 64'(exp_illegal), 64'(illegal));
        check_val({name, " jmp"}, 64'(exp_jmp), 64'(jmp));
        check_val({name, " next_pc"}, exp_next_pc, next_pc);
        model = nxt;
    endtask

    task automatic access_cycle(input logic [11:0] addr, input logic [4:0] fld,
                                input logic [2:0] f3, input logic [63:0] rs1, input string name);
        drive_cycle(encode_instr(addr, fld, f3), rs1, 1'b1, 1'b0, '0, '0, 1'b0, name);
    endtask

    // ============================================================
    // tests
    // ============================================================
    task automatic directed_tests();
        logic [11:0] a;
        drive_cycle('0, '0, 1'b0, 1'b0, '0, '0, 1'b0, "idle_after_reset");
        for (int i = 0; i < 4; i++) begin
            access_cycle(known_addr(2'(i)), 5'd0, csr_pkg::f3_csrrs, rand64(), "reset_read");
        end
        for (int i = 0; i < 4; i++) begin
            a = known_addr(2'(i));
            access_cycle(a, 5'd3, csr_pkg::f3_csrrw, rand64(), "csrrw");
            access_cycle(a, 5'd0, csr_pkg::f3_csrrs, '0, "csrrw_read");
            access_cycle(a, 5'(i + 17), csr_pkg::f3_csrrwi, rand64(), "csrrwi");
            access_cycle(a, 5'd0, csr_pkg::f3_csrrs, '0, "csrrwi_read");
        end
        for (int i = 0; i < 4; i++) begin
            a = known_addr(2'(i));
            access_cycle(a, 5'd7, csr_pkg::f3_csrrs, rand64(), "csrrs");
            access_cycle(a, 5'd8, csr_pkg::f3_csrrc, rand64(), "csrrc");
            access_cycle(a, 5'd21, csr_pkg::f3_csrrsi, '0, "csrrsi");
            access_cycle(a, 5'd5, csr_pkg::f3_csrrci, '0, "csrrci");
            access_cycle(a, 5'd0, csr_pkg::f3_csrrc, '1, "csrrc_x0");
            access_cycle(a, 5'd0, csr_pkg::f3_csrrsi, '1, "set_clear_read");
        end
        access_cycle(csr_pkg::addr_mtvec, 5'd1, 3'd0, rand64(), "illegal_f3_0");
        access_cycle(csr_pkg::addr_mtvec, 5'd1, 3'd4, rand64(), "illegal_f3_4");
        access_cycle(csr_pkg::addr_mtvec, 5'd0, csr_pkg::f3_csrrs, '0, "illegal_read");
        access_cycle(12'h7c0, 5'd1, csr_pkg::f3_csrrw, rand64(), "unknown_write");
        access_cycle(12'h7c0, 5'd0, csr_pkg::f3_csrrs, '0, "unknown_read");
        // MPIE cleared and MIE set first so that the trap has something to move into MPIE
        access_cycle(csr_pkg::addr_mstatus, 5'd1, csr_pkg::f3_csrrc, 64'h80, "clear_mpie");
        access_cycle(csr_pkg::addr_mstatus, 5'd8, csr_pkg::f3_csrrsi, '0, "set_mie");
        drive_cycle('0, '0, 1'b0, 1'b1, rand64(), rand64(), 1'b0, "trap");
        for (int i = 0; i < 4; i++) begin
            access_cycle(known_addr(2'(i)), 5'd0, csr_pkg::f3_csrrs, '0, "trap_read");
        end
        drive_cycle('0, '0, 1'b0, 1'b0, '0, '0, 1'b1, "mret");
        access_cycle(csr_pkg::addr_mstatus, 5'd0, csr_pkg::f3_csrrs, '0, "mret_read");
        drive_cycle(encode_instr(csr_pkg::addr_mepc, 5'd1, csr_pkg::f3_csrrw), rand64(),
                    1'b1, 1'b1, rand64(), rand64(), 1'b1, "prio_mret");
        drive_cycle(encode_instr(csr_pkg::addr_mcause, 5'd1, csr_pkg::f3_csrrw), rand64(),
                    1'b1, 1'b1, rand64(), rand64(), 1'b0, "prio_write");
        drive_cycle(encode_instr(csr_pkg::addr_mtvec, 5'd1, 3'd4), rand64(),
                    1'b1, 1'b1, rand64(), rand64(), 1'b0, "prio_illegal_trap");
        for (int i = 0; i < 4; i++) begin
            access_cycle(known_addr(2'(i)), 5'd0, csr_pkg::f3_csrrs, '0, "prio_read");
        end
    endtask

    task automatic random_tests();
        logic [31:0] r;
        logic [11:0] addr;
        logic [4:0]  fld;
        for (int n = 0; n < num_random; n++) begin
            r = $random(seed);
            if (r[1:0] != 2'b00) begin
                addr = known_addr(r[3:2]);  // three of four accesses hit a known csr
            end else begin
                addr = r[31:20];
            end
            fld = (r[5:4] == 2'b00) ? 5'd0 : r[10:6];
            drive_cycle(encode_instr(addr, fld, r[13:11]), rand64(), r[15:14] != 2'b00,
                        r[18:16] == 3'd0, rand64(), rand64(), r[21:19] == 3'd0, "random");
        end
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================
    initial begin
        rst        <= 1'b1;
        instr      <= '0;
        rs1_val    <= '0;
        csr_valid  <= 1'b0;
        raise_intr <= 1'b0;
        intr_cause <= '0;
        pc         <= '0;
        mret       <= 1'b0;
        model = reset_state();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        directed_tests();
        random_tests();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(max_cycles * clk_period + 100);
        $display("timeout: tests did not finish within %0d cycles, errors so far: %0d",
                 max_cycles, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+test
hdl/csr_pkg.sv
hdl/csr_access_if.sv
hdl/csr_op_unit.sv
hdl/csr_regfile.sv
hdl/csr_exec.sv
hdl/csr_unit_top.sv
test/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the CSR testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f tb.f \
    --top-module csr_unit_tb --Mdir obj_dir -o csr_sim

out=$(./obj_dir/csr_sim)
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
